//--- rtl/classifierTop.sv
`default_nettype none

module classifierTop (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input nnPkg::activation_t inData,
	output logic outStrobe,
	output nnPkg::neuronIndex_t outIndex,
	output nnPkg::activation_t outData,
	output logic classStrobe,
	output nnPkg::neuronIndex_t classIndex
);

	logic sampleStrobe;
	nnPkg::activation_t sampleData;
	nnPkg::sampleIndex_t sampleIndex;
	logic firstSample;
	logic lastSample;
	nnPkg::activation_t result0;
	nnPkg::activation_t result1;
	nnPkg::activation_t result2;
	nnPkg::activation_t result3;
	logic layerDone;

	sampleSequencer sequencer_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.inData(inData),
		.sampleStrobe(sampleStrobe),
		.sampleData(sampleData),
		.sampleIndex(sampleIndex),
		.firstSample(firstSample),
		.lastSample(lastSample)
	);

	denseLayer layer_i (
		.clk(clk),
		.reset(reset),
		.sampleStrobe(sampleStrobe),
		.sampleData(sampleData),
		.sampleIndex(sampleIndex),
		.firstSample(firstSample),
		.lastSample(lastSample),
		.result0(result0),
		.result1(result1),
		.result2(result2),
		.result3(result3),
		.layerDone(layerDone)
	);

	resultSerializer serializer_i (
		.clk(clk),
		.reset(reset),
		.layerDone(layerDone),
		.result0(result0),
		.result1(result1),
		.result2(result2),
		.result3(result3),
		.outStrobe(outStrobe),
		.outIndex(outIndex),
		.outData(outData),
		.classStrobe(classStrobe),
		.classIndex(classIndex)
	);

endmodule

`default_nettype wire

//--- rtl/denseLayer.sv
`default_nettype none

module denseLayer (
	input logic clk,
	input logic reset,
	input logic sampleStrobe,
	input nnPkg::activation_t sampleData,
	input nnPkg::sampleIndex_t sampleIndex,
	input logic firstSample,
	input logic lastSample,
	output nnPkg::activation_t result0,
	output nnPkg::activation_t result1,
	output nnPkg::activation_t result2,
	output nnPkg::activation_t result3,
	output logic layerDone
);

	nnPkg::activation_t results [nnPkg::numNeurons];
	logic [nnPkg::numNeurons-1:0] valid;

	for (genvar n = 0; n < nnPkg::numNeurons; n++)
	begin : neuron
		neuronMac #(
			.neuronId(n)
		) mac_i (
			.clk(clk),
			.reset(reset),
			.sampleStrobe(sampleStrobe),
			.sampleData(sampleData),
			.sampleIndex(sampleIndex),
			.firstSample(firstSample),
			.lastSample(lastSample),
			.result(results[n]),
			.resultValid(valid[n])
		);
	end

	assign result0 = results[0];
	assign result1 = results[1];
	assign result2 = results[2];
	assign result3 = results[3];
	assign layerDone = valid[0]; // All neurons finish on the same edge.

	neuronsInStep: assert property (@(posedge clk) disable iff (reset)
		(valid == '0) || (valid == '1))
		else $error("Neurons finished on different cycles.");

endmodule

`default_nettype wire

//--- rtl/neuronMac.sv
`default_nettype none

module neuronMac #(
	parameter int neuronId = 0
) (
	input logic clk,
	input logic reset,
	input logic sampleStrobe,
	input nnPkg::activation_t sampleData,
	input nnPkg::sampleIndex_t sampleIndex,
	input logic firstSample,
	input logic lastSample,
	output nnPkg::activation_t result,
	output logic resultValid
);

	nnPkg::weight_t weight;
	logic signed [15:0] product;
	nnPkg::acc_t acc;
	nnPkg::acc_t scaled;
	logic finishPending; // The last product went into acc on the previous edge.

	assign weight = nnPkg::weightTable[neuronId][sampleIndex];
	assign product = weight * sampleData;
	assign scaled = acc >>> nnPkg::fracBits;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			finishPending <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			finishPending <= sampleStrobe && lastSample;
			resultValid <= finishPending;
		end
	end

	////////////////////////////////////////
	// Accumulate, then activate

	always_ff @(posedge clk)
	begin
		if (sampleStrobe)
		begin
			if (firstSample) // Bias enters once, with the first product.
				acc <= nnPkg::acc_t'(nnPkg::biasTable[neuronId]) + nnPkg::acc_t'(product);
			else
				acc <= acc + nnPkg::acc_t'(product);
		end

		// ReLU, rescale, then clamp to the activation range.
		if (finishPending)
		begin
			if (acc < 0)
				result <= '0;
			else if (scaled > nnPkg::acc_t'(nnPkg::maxActivation))
				result <= nnPkg::maxActivation;
			else
				result <= scaled[7:0];
		end
	end

endmodule

`default_nettype wire

//--- rtl/nnPkg.sv
`default_nettype none

package nnPkg;

	////////////////////////////////////////
	// Sizes and scaling

	localparam int numInputs = 30;
	localparam int numNeurons = 4;
	localparam int fracBits = 6; // Fixed point position of the weights.

	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [19:0] acc_t; // Holds 30 full products plus the bias.
	typedef logic [4:0] sampleIndex_t;
	typedef logic [1:0] neuronIndex_t;

	localparam activation_t maxActivation = 8'sd127;

	////////////////////////////////////////
	// Fixed layer coefficients

	// One row per neuron, one column per feature.
	localparam weight_t weightTable [numNeurons][numInputs] = '{
		'{
			23, -41, 17, 66, -8, 35, -72, 12, 49, -27,
			5, 88, -19, 40, -55, 31, 9, -64, 27, 14,
			-36, 71, -3, 18, 52, -90, 44, 7, -22, 60
		},
		'{
			-14, 29, 53, -77, 38, 6, 21, -45, 80, -11,
			47, -33, 15, 92, -58, 24, -6, 39, -70, 13,
			58, -25, 34, 1, -49, 67, -18, 26, 43, -83
		},
		'{
			61, 8, -37, 25, -94, 50, 16, 33, -20, 74,
			-42, 19, 57, -9, 28, -66, 45, 11, 36, -51,
			4, 82, -29, 63, 10, -39, 22, -75, 55, 30
		},
		'{
			-50, 73, 2, -31, 46, 20, -87, 59, 13, 37,
			-16, -62, 41, 26, 69, -4, -48, 85, 17, -28,
			32, -7, 76, -56, 48, 15, -34, 51, -2, 64
		}
	};

	localparam weight_t biasTable [numNeurons] = '{18, -12, 5, -30};

endpackage

`default_nettype wire

//--- rtl/resultSerializer.sv
`default_nettype none

module resultSerializer (
	input logic clk,
	input logic reset,
	input logic layerDone,
	input nnPkg::activation_t result0,
	input nnPkg::activation_t result1,
	input nnPkg::activation_t result2,
	input nnPkg::activation_t result3,
	output logic outStrobe,
	output nnPkg::neuronIndex_t outIndex,
	output nnPkg::activation_t outData,
	output logic classStrobe,
	output nnPkg::neuronIndex_t classIndex
);

	typedef enum logic [1:0] {idle, emit, classify} serState_t;

	serState_t state;
	nnPkg::activation_t bank [nnPkg::numNeurons];
	nnPkg::neuronIndex_t slot;
	nnPkg::activation_t bestValue;
	nnPkg::neuronIndex_t bestIndex;
	logic capture;

	assign capture = layerDone && (state == idle);
	assign outStrobe = (state == emit);
	assign outIndex = slot;
	assign outData = bank[slot];
	assign classStrobe = (state == classify);
	assign classIndex = bestIndex;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			slot <= '0;
		end
		else
		begin
			case (state)
				idle:
					if (layerDone)
					begin
						state <= emit;
						slot <= '0;
					end
				emit:
				begin
					slot <= slot + 1'b1;
					if (slot == nnPkg::neuronIndex_t'(nnPkg::numNeurons - 1))
						state <= classify;
				end
				default: state <= idle;
			endcase
		end
	end

	// Running maximum. Strict compare keeps the lower index on a tie.
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			bank[0] <= result0;
			bank[1] <= result1;
			bank[2] <= result2;
			bank[3] <= result3;
			bestValue <= result0;
			bestIndex <= '0;
		end
		else if ((state == emit) && (bank[slot] > bestValue))
		begin
			bestValue <= bank[slot];
			bestIndex <= slot;
		end
	end

	doneWhileIdle: assert property (@(posedge clk) disable iff (reset)
		layerDone |-> (state == idle))
		else $error("Layer results arrived while the previous frame was still going out.");

endmodule

`default_nettype wire

//--- rtl/sampleSequencer.sv
`default_nettype none

module sampleSequencer (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input nnPkg::activation_t inData,
	output logic sampleStrobe,
	output nnPkg::activation_t sampleData,
	output nnPkg::sampleIndex_t sampleIndex,
	output logic firstSample,
	output logic lastSample
);

	nnPkg::sampleIndex_t count;
	logic lastOfFrame;

	assign lastOfFrame = (count == nnPkg::sampleIndex_t'(nnPkg::numInputs - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			sampleStrobe <= 1'b0;
		end
		else
		begin
			sampleStrobe <= inStrobe;
			if (inStrobe)
				count <= lastOfFrame ? '0 : count + 1'b1; // Wrap at the end of a frame.
		end
	end

	// Feature and its position travel together with the strobe.
	always_ff @(posedge clk)
	begin
		if (inStrobe)
		begin
			sampleData <= inData;
			sampleIndex <= count;
			firstSample <= (count == '0);
			lastSample <= lastOfFrame;
		end
	end

	countInRange: assert property (@(posedge clk) disable iff (reset)
		count < nnPkg::sampleIndex_t'(nnPkg::numInputs))
		else $error("Feature counter left its frame range.");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the classifier testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module classifierTb -f tb.f -o classifierSim \
	&& ./obj_dir/classifierSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete."; exit 1; }

cat sim.log

# The run fails if the testbench reported a failure.
grep -q "Regression failed" sim.log && exit 1 || exit 0

//--- tb.f
rtl/nnPkg.sv
rtl/sampleSequencer.sv
rtl/neuronMac.sv
rtl/denseLayer.sv
rtl/resultSerializer.sv
rtl/classifierTop.sv
tests/classifierTb.sv

//--- tests/classifierTb.sv
`default_nettype none

module classifierTb;

	localparam int framesExpected = 6;
	localparam int fieldsPerFrame = nnPkg::numInputs + nnPkg::numNeurons + 1;
	localparam int cycleLimit = framesExpected * nnPkg::numInputs * 4 + 100; // Gaps reach 3 cycles.
	localparam int kindOut = 0;
	localparam int kindClass = 1;

	logic clk;
	logic reset;
	logic inStrobe;
	nnPkg::activation_t inData;
	logic outStrobe;
	nnPkg::neuronIndex_t outIndex;
	nnPkg::activation_t outData;
	logic classStrobe;
	nnPkg::neuronIndex_t classIndex;

	int features[$]; // All frames, one after the other.
	int expKind[$];
	int expIndex[$];
	int expData[$];
	int fields[$];
	int frameCount = 0;
	int sentCount = 0;
	int cycle = 0;
	int lastOutCycle = -10;
	int checkCount = 0;
	int valueErrors = 0;
	int otherErrors = 0;

	classifierTop dut_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.inData(inData),
		.outStrobe(outStrobe),
		.outIndex(outIndex),
		.outData(outData),
		.classStrobe(classStrobe),
		.classIndex(classIndex)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers

	task automatic checkValue(input string name, input int actual, input int expected);
		checkCount++;
		if (actual != expected)
		begin
			valueErrors++;
			$display("ERR %0t %s: got %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// Splits one text line into signed decimal numbers.
	task automatic splitFields(input string line);
		int value;
		int pos;
		bit inNumber;
		bit negative;
		byte ch;
		value = 0;
		inNumber = 1'b0;
		negative = 1'b0;
		fields.delete();
		for (pos = 0; pos < line.len(); pos++)
		begin
			ch = line.getc(pos);
			if (ch == "-")
				negative = 1'b1;
			else if (ch >= "0" && ch <= "9")
			begin
				value = value * 10 + (int'(ch) - 48);
				inNumber = 1'b1;
			end
			else
			begin
				if (inNumber)
					fields.push_back(negative ? -value : value);
				value = 0;
				inNumber = 1'b0;
				negative = 1'b0;
			end
		end
		if (inNumber)
			fields.push_back(negative ? -value : value);
	endtask

	task automatic readPatterns();
		int fd;
		int n;
		string line;
		fd = $fopen("tests/framePatterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file tests/framePatterns.txt.");
			otherErrors++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			splitFields(line);
			if (fields.size() != fieldsPerFrame)
			begin
				$display("A pattern line holds %0d numbers instead of %0d.", fields.size(),
					fieldsPerFrame);
				otherErrors++;
				continue;
			end
			for (n = 0; n < nnPkg::numInputs; n++)
				features.push_back(fields[n]);
			for (n = 0; n < nnPkg::numNeurons; n++)
			begin
				expKind.push_back(kindOut);
				expIndex.push_back(n);
				expData.push_back(fields[nnPkg::numInputs + n]);
			end
			expKind.push_back(kindClass); // The class closes every frame.
			expIndex.push_back(fields[fieldsPerFrame - 1]);
			expData.push_back(0);
			frameCount++;
		end
		$fclose(fd);
	endtask

	task automatic driveFrame(input int frame, input bit withGaps);
		int gap;
		int i;
		for (i = 0; i < nnPkg::numInputs; i++)
		begin
			gap = withGaps ? int'($urandom % 4) : 0;
			repeat (gap)
			begin
				@(posedge clk);
				#1;
				inStrobe = 1'b0;
			end
			@(posedge clk);
			#1;
			inStrobe = 1'b1;
			inData = nnPkg::activation_t'(features[frame * nnPkg::numInputs + i]);
			sentCount++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus

	initial
	begin : stimulus
		int f;
		reset = 1'b1;
		inStrobe = 1'b0;
		inData = '0;
		void'($urandom(32'h6584));
		readPatterns();
		if (frameCount != framesExpected)
		begin
			$display("The pattern file gave %0d frames instead of %0d.", frameCount, framesExpected);
			otherErrors++;
		end
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// Even frames go back-to-back, odd frames get idle gaps.
		for (f = 0; f < frameCount; f++)
			driveFrame(f, (f % 2) == 1);
		@(posedge clk);
		#1;
		inStrobe = 1'b0;

		while (expKind.size() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk); // A stray strobe would still be caught here.

		$display("Checks %0d, value errors %0d, other errors %0d", checkCount, valueErrors,
			otherErrors);
		if (valueErrors == 0 && otherErrors == 0 && checkCount > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	////////////////////////////////////////
	// Output monitor and timeout

	always @(negedge clk)
	begin : monitor
		int kind;
		int index;
		int data;
		if (outStrobe || classStrobe)
		begin
			if (sentCount < nnPkg::numInputs)
			begin
				$display("An output strobe came at %0t before the first frame was complete.", $time);
				otherErrors++;
			end
			else if (outStrobe && classStrobe)
			begin
				$display("outStrobe and classStrobe were both high at %0t.", $time);
				otherErrors++;
			end
			else if (expKind.size() == 0)
			begin
				$display("An output strobe came at %0t with no result left to expect.", $time);
				otherErrors++;
			end
			else
			begin
				kind = expKind.pop_front();
				index = expIndex.pop_front();
				data = expData.pop_front();
				if ((outStrobe ? kindOut : kindClass) != kind)
				begin
					$display("Output events came out of order at %0t.", $time);
					otherErrors++;
				end
				else if (outStrobe)
				begin
					checkValue("outIndex", int'(outIndex), index);
					checkValue("outData", int'(outData), data);
					lastOutCycle = cycle;
				end
				else
				begin
					checkValue("classIndex", int'(classIndex), index);
					checkValue("classStrobe delay", cycle - lastOutCycle, 1);
				end
			end
		end
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			cycle++;
			if (cycle >= cycleLimit)
			begin
				$display("Timeout after %0d cycles, not all frame results arrived.", cycle);
				$display("Regression failed");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/framePatterns.txt
# Each line is one frame: 30 signed features, then the 4 expected neuron results,
# then the expected class index. All numbers are decimal.
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 3 2 4 4 2
-1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 0 0 0 0 0
127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 0
10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 36 30 41 54 3
0 0 0 0 0 0 0 0 20 0 0 0 0 40 0 0 0 0 0 0 0 0 0 0 0 30 0 0 0 0 0 113 0 26 1
-20 0 0 0 0 0 -35 0 0 0 0 0 0 0 0 0 0 45 0 0 0 0 90 0 0 0 0 0 0 -15 0 87 0 127 3
